/* build.f */
+incdir+common
common/apb_iob_pkg.sv
hw/apb2iob/apb2iob.sv
hw/iob_csrs/iob_csrs.sv
hw/iob_timer/iob_timer.sv
hw/apb_timer_top.sv
dv/tb_clk_gen.sv
dv/apb_timer_tb.sv

/* dv/apb_timer_tb.sv */
`include "apb_iob_macros.svh"

module apb_timer_tb
   import apb_iob_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int WATCHDOG_CYCLES = 2000;  // Tests need about 400 cycles
   localparam int READY_LIMIT     = 8;
   localparam int POLL_LIMIT      = 12;
   localparam logic [31:0] CTRL_EN     = 32'h1 << `CTRL_EN_BIT;
   localparam logic [31:0] CTRL_RELOAD = 32'h1 << `CTRL_RELOAD_BIT;
   localparam logic [31:0] CTRL_IRQEN  = 32'h1 << `CTRL_IRQEN_BIT;

   logic        clk;
   logic        rst_n;
   apb_req_t    apb_req;
   apb_resp_t   apb_resp;
   logic        irq;

   tb_clk_gen #(.PERIOD_NS(100)) tb_clk_gen_inst (.clk_o(clk));

   apb_timer_top apb_timer_top_inst (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .apb_req_i (apb_req),
      .apb_resp_o(apb_resp),
      .irq_o     (irq)
   );

   task automatic fail_run();
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped after a failure");
   endtask

   task automatic check_eq(input string test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
         fail_run();
      end
   endtask

   // Byte lanes selected by a write strobe
   function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
      return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
   endfunction

   // One APB transfer through setup and access until ready
   task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               output logic [31:0] rdata);
      int waited;
      waited = 0;
      @(negedge clk);
      apb_req.sel    = 1'b1;
      apb_req.enable = 1'b0;
      apb_req.write  = wr;
      apb_req.addr   = addr;
      apb_req.wdata  = wr ? wdata : 32'h0;
      apb_req.wstrb  = wr ? strb : 4'h0;
      @(negedge clk);
      apb_req.enable = 1'b1;
      @(negedge clk);
      while (!apb_resp.ready) begin
         waited++;
         if (waited > READY_LIMIT) begin
            $display("APB transfer to 0x%02h never got ready", addr);
            fail_run();
         end
         @(negedge clk);
      end
      check_eq("apb_transfer wait states", 32'h0, waited);  // One wait state only
      rdata = apb_resp.rdata;  // Valid while ready is high
      @(negedge clk);
      check_eq("apb_transfer ready one cycle", 32'h0, {31'b0, apb_resp.ready});
      apb_req = '0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic [31:0] unused;
      apb_transfer(1'b1, addr, data, strb, unused);
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      apb_transfer(1'b0, addr, 32'h0, 4'h0, data);
   endtask

   task automatic reset_values();
      logic [7:0]  regs [6];
      logic [31:0] rd;
      regs = '{`REG_CTRL, `REG_PRESC, `REG_CMP, `REG_COUNT, `REG_STATUS, `REG_SCRATCH};
      foreach (regs[i]) begin
         apb_read(regs[i], rd);
         check_eq($sformatf("reset_values reg 0x%02h", regs[i]), 32'h0, rd);
      end
      check_eq("reset_values irq", 32'h0, {31'b0, irq});
   endtask

   task automatic csr_rw_strobes();
      logic [3:0]  strbs [4];
      logic [31:0] model;
      logic [31:0] wd;
      logic [31:0] rd;
      strbs = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
      model = $urandom;
      apb_write(`REG_CMP, model, 4'hF);
      apb_read(`REG_CMP, rd);
      check_eq("csr_rw_strobes CMP full", model, rd);
      wd    = $urandom;
      model = (model & ~strobe_mask(4'b0101)) | (wd & strobe_mask(4'b0101));
      apb_write(`REG_CMP, wd, 4'b0101);
      apb_read(`REG_CMP, rd);
      check_eq("csr_rw_strobes CMP partial", model, rd);
      model = $urandom;
      apb_write(`REG_SCRATCH, model, 4'hF);
      foreach (strbs[i]) begin
         wd    = $urandom;
         model = (model & ~strobe_mask(strbs[i])) | (wd & strobe_mask(strbs[i]));
         apb_write(`REG_SCRATCH, wd, strbs[i]);
         apb_read(`REG_SCRATCH, rd);
         check_eq("csr_rw_strobes SCRATCH", model, rd);
      end
      wd = $urandom;
      apb_write(`REG_PRESC, wd, 4'hF);
      apb_read(`REG_PRESC, rd);
      check_eq("csr_rw_strobes PRESC 16 bits", {16'h0, wd[15:0]}, rd);
      apb_write(`REG_PRESC, $urandom, 4'b1100);  // Upper lanes only leave PRESC unchanged
      apb_read(`REG_PRESC, rd);
      check_eq("csr_rw_strobes PRESC upper", {16'h0, wd[15:0]}, rd);
      apb_write(8'h18, $urandom, 4'hF);
      apb_read(8'h18, rd);
      check_eq("csr_rw_strobes unmapped 0x18", 32'h0, rd);
      apb_read(8'hFC, rd);
      check_eq("csr_rw_strobes unmapped 0xFC", 32'h0, rd);
      apb_read(`REG_SCRATCH, rd);
      check_eq("csr_rw_strobes SCRATCH kept", model, rd);
      apb_write(`REG_PRESC, 32'h0, 4'hF);
   endtask

   task automatic count_load_frozen();
      logic [31:0] val;
      logic [31:0] rd;
      apb_write(`REG_CTRL, 32'h0, 4'hF);
      val = $urandom;
      apb_write(`REG_COUNT, val, 4'hF);
      apb_read(`REG_COUNT, rd);
      check_eq("count_load_frozen first read", val, rd);
      repeat (6) @(negedge clk);
      apb_read(`REG_COUNT, rd);
      check_eq("count_load_frozen second read", val, rd);
   endtask

   task automatic match_irq();
      logic [31:0] rd;
      int          polls;
      apb_write(`REG_PRESC, 32'h0, 4'hF);
      apb_write(`REG_CMP, 32'd5, 4'hF);
      apb_write(`REG_COUNT, 32'h0, 4'hF);
      apb_write(`REG_CTRL, CTRL_IRQEN, 4'hF);
      check_eq("match_irq irq before enable", 32'h0, {31'b0, irq});
      apb_write(`REG_CTRL, CTRL_IRQEN | CTRL_EN, 4'hF);
      polls = 0;
      do begin
         apb_read(`REG_STATUS, rd);
         polls++;
      end while (!rd[`STATUS_MATCH_BIT] && polls < POLL_LIMIT);
      check_eq("match_irq STATUS flag", 32'h1, rd);
      check_eq("match_irq irq set", 32'h1, {31'b0, irq});
      apb_write(`REG_CTRL, CTRL_IRQEN, 4'hF);
      apb_write(`REG_STATUS, 32'h1, 4'hF);  // Write one to clear
      apb_read(`REG_STATUS, rd);
      check_eq("match_irq STATUS cleared", 32'h0, rd);
      check_eq("match_irq irq cleared", 32'h0, {31'b0, irq});
   endtask

   task automatic auto_reload();
      logic [31:0] rd;
      logic [31:0] start;
      logic        seen_zero;
      logic        seen_three;
      apb_write(`REG_CTRL, 32'h0, 4'hF);
      apb_write(`REG_PRESC, 32'd2, 4'hF);
      apb_write(`REG_CMP, 32'd3, 4'hF);
      apb_write(`REG_COUNT, 32'h0, 4'hF);
      apb_write(`REG_CTRL, CTRL_EN | CTRL_RELOAD, 4'hF);
      seen_zero  = 1'b0;
      seen_three = 1'b0;
      for (int i = 0; i < 20; i++) begin
         apb_read(`REG_COUNT, rd);
         check_eq("auto_reload COUNT at most CMP", 32'h1, {31'b0, rd <= 32'd3});
         seen_zero  = seen_zero | (rd == 32'd0);
         seen_three = seen_three | (rd == 32'd3);
         repeat (i % 5) @(negedge clk);  // Spread samples over the 12 cycle period
      end
      check_eq("auto_reload saw 0", 32'h1, {31'b0, seen_zero});
      check_eq("auto_reload saw CMP", 32'h1, {31'b0, seen_three});
      apb_write(`REG_CTRL, 32'h0, 4'hF);
      apb_write(`REG_STATUS, 32'h1, 4'hF);
      start = 32'd100 + ($urandom % 1000);
      apb_write(`REG_COUNT, start, 4'hF);
      apb_write(`REG_CTRL, CTRL_EN, 4'hF);
      for (int i = 0; i < 6; i++) begin
         apb_read(`REG_STATUS, rd);
         check_eq("auto_reload no match above CMP", 32'h0, rd);
         repeat (2) @(negedge clk);
      end
      apb_read(`REG_COUNT, rd);
      check_eq("auto_reload COUNT advanced", 32'h1, {31'b0, rd > start});
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      fail_run();
   end

   initial begin
      rst_n   = 1'b0;
      apb_req = '0;
      void'($urandom(19));
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      reset_values();
      csr_rw_strobes();
      count_load_frozen();
      match_irq();
      auto_reload();
      $display("TEST PASS");
      $finish;
   end

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen #(
   parameter int PERIOD_NS = 100
)(
   output logic clk_o
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
   end

   always begin
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // Free running
   end

endmodule

/* hw/apb_timer_top.sv */
module apb_timer_top
   import apb_iob_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  apb_req_t  apb_req_i,
   output apb_resp_t apb_resp_o,
   output logic      irq_o
);

   iob_req_t    iob_req;
   iob_resp_t   iob_resp;
   timer_cfg_t  tmr_cfg;
   timer_stat_t tmr_stat;

   apb2iob apb2iob_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .apb_req_i (apb_req_i),
      .apb_resp_o(apb_resp_o),
      .iob_req_o (iob_req),
      .iob_resp_i(iob_resp)
   );

   iob_csrs iob_csrs_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .iob_req_i (iob_req),
      .iob_resp_o(iob_resp),
      .tmr_cfg_o (tmr_cfg),
      .tmr_stat_i(tmr_stat),
      .irq_o     (irq_o)
   );

   iob_timer iob_timer_inst (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .cfg_i  (tmr_cfg),
      .stat_o (tmr_stat)
   );

endmodule

/* hw/iob_timer/iob_timer.sv */
`include "apb_iob_macros.svh"

module iob_timer
   import apb_iob_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  timer_cfg_t  cfg_i,
   output timer_stat_t stat_o
);

   logic [`TMR_PRESC_W-1:0] presc_cnt_q;
   logic [`TMR_COUNT_W-1:0] count_q;
   logic [`TMR_COUNT_W-1:0] count_nxt;
   logic                    match_q;
   logic                    tick;

   // Prescaler wrap, also catches presc lowered below the running value
   assign tick = cfg_i.en && (presc_cnt_q >= cfg_i.presc);

   // Reload wraps to zero once compare was reached
   assign count_nxt = (cfg_i.reload && (count_q == cfg_i.cmp)) ? '0 : count_q + 1'b1;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         presc_cnt_q <= '0;
      end else if (cfg_i.load || !cfg_i.en) begin
         presc_cnt_q <= '0;  // Restart period
      end else if (tick) begin
         presc_cnt_q <= '0;
      end else begin
         presc_cnt_q <= presc_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else if (cfg_i.load) begin
         count_q <= cfg_i.load_val;  // Load wins even when disabled
      end else if (tick) begin
         count_q <= count_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         match_q <= 1'b0;
      end else begin
         match_q <= tick && !cfg_i.load && (count_nxt == cfg_i.cmp);
      end
   end

   always_comb begin
      stat_o.count = count_q;
      stat_o.match = match_q;
   end

endmodule

/* hw/iob_csrs/iob_csrs.sv */
`include "apb_iob_macros.svh"

module iob_csrs
   import apb_iob_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  iob_req_t    iob_req_i,
   output iob_resp_t   iob_resp_o,
   output timer_cfg_t  tmr_cfg_o,
   input  timer_stat_t tmr_stat_i,
   output logic        irq_o
);

   logic [`CTRL_W-1:0]      ctrl_q;
   logic [`TMR_PRESC_W-1:0] presc_q;
   logic [`TMR_COUNT_W-1:0] cmp_q;
   logic [`APB_DATA_W-1:0]  scratch_q;
   logic                    match_flag_q;
   logic                    load_q;
   logic [`TMR_COUNT_W-1:0] load_val_q;
   logic [`APB_DATA_W-1:0]  rdata_q;
   logic [`APB_DATA_W-1:0]  rdata_d;
   logic                    wr_en;
   logic                    rd_en;
   logic                    clr_match;
   logic [`APB_ADDR_W-1:0]  word_addr;
   logic [`APB_DATA_W-1:0]  ctrl_wide;
   logic [`APB_DATA_W-1:0]  presc_wide;
   logic [`APB_DATA_W-1:0]  ctrl_mrg;
   logic [`APB_DATA_W-1:0]  presc_mrg;
   logic [`APB_DATA_W-1:0]  cmp_mrg;
   logic [`APB_DATA_W-1:0]  scratch_mrg;
   logic [`APB_DATA_W-1:0]  count_mrg;

   // Byte lanes with a strobe take the new value
   function automatic logic [`APB_DATA_W-1:0] merge_bytes(
      input logic [`APB_DATA_W-1:0] old_val,
      input logic [`APB_DATA_W-1:0] new_val,
      input logic [`APB_STRB_W-1:0] strb
   );
      logic [`APB_DATA_W-1:0] res;
      res = old_val;
      for (int b = 0; b < `APB_STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign wr_en     = iob_req_i.avalid && (|iob_req_i.wstrb);
   assign rd_en     = iob_req_i.avalid && !(|iob_req_i.wstrb);
   assign word_addr = {iob_req_i.addr[`APB_ADDR_W-1:2], 2'b00};  // Ignore byte offset

   assign ctrl_wide  = {{(`APB_DATA_W - `CTRL_W){1'b0}}, ctrl_q};
   assign presc_wide = {{(`APB_DATA_W - `TMR_PRESC_W){1'b0}}, presc_q};

   assign ctrl_mrg    = merge_bytes(ctrl_wide, iob_req_i.wdata, iob_req_i.wstrb);
   assign presc_mrg   = merge_bytes(presc_wide, iob_req_i.wdata, iob_req_i.wstrb);
   assign cmp_mrg     = merge_bytes(cmp_q, iob_req_i.wdata, iob_req_i.wstrb);
   assign scratch_mrg = merge_bytes(scratch_q, iob_req_i.wdata, iob_req_i.wstrb);
   assign count_mrg   = merge_bytes(tmr_stat_i.count, iob_req_i.wdata, iob_req_i.wstrb);

   // Write one to clear
   assign clr_match = wr_en && (word_addr == `REG_STATUS)
                      && iob_req_i.wstrb[`STATUS_MATCH_BIT / 8]
                      && iob_req_i.wdata[`STATUS_MATCH_BIT];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_q    <= `CTRL_RST;
         presc_q   <= `PRESC_RST;
         cmp_q     <= `CMP_RST;
         scratch_q <= `SCRATCH_RST;
      end else if (wr_en) begin
         case (word_addr)
            `REG_CTRL:    ctrl_q    <= ctrl_mrg[`CTRL_W-1:0];
            `REG_PRESC:   presc_q   <= presc_mrg[`TMR_PRESC_W-1:0];  // Upper half dropped
            `REG_CMP:     cmp_q     <= cmp_mrg;
            `REG_SCRATCH: scratch_q <= scratch_mrg;
            default:      ;  // Unmapped, no effect
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         match_flag_q <= `STATUS_RST;
         load_q       <= 1'b0;
      end else begin
         load_q <= wr_en && (word_addr == `REG_COUNT);
         if (tmr_stat_i.match) begin
            match_flag_q <= 1'b1;  // Set beats clear
         end else if (clr_match) begin
            match_flag_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      load_val_q <= count_mrg;
   end

   always_comb begin
      case (word_addr)
         `REG_CTRL:    rdata_d = ctrl_wide;
         `REG_PRESC:   rdata_d = presc_wide;
         `REG_CMP:     rdata_d = cmp_q;
         `REG_COUNT:   rdata_d = tmr_stat_i.count;
         `REG_STATUS:  rdata_d = {{(`APB_DATA_W - 1){1'b0}}, match_flag_q};
         `REG_SCRATCH: rdata_d = scratch_q;
         default:      rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= rdata_d;
      end
   end

   // Always answers in the first avalid cycle
   always_comb begin
      iob_resp_o.ready_nxt  = iob_req_i.avalid;
      iob_resp_o.rvalid_nxt = rd_en;
      iob_resp_o.rdata      = rdata_q;
   end

   always_comb begin
      tmr_cfg_o.en       = ctrl_q[`CTRL_EN_BIT];
      tmr_cfg_o.reload   = ctrl_q[`CTRL_RELOAD_BIT];
      tmr_cfg_o.presc    = presc_q;
      tmr_cfg_o.cmp      = cmp_q;
      tmr_cfg_o.load     = load_q;
      tmr_cfg_o.load_val = load_val_q;
   end

   assign irq_o = match_flag_q && ctrl_q[`CTRL_IRQEN_BIT];

endmodule

/* hw/apb2iob/apb2iob.sv */
module apb2iob
   import apb_iob_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  apb_req_t  apb_req_i,
   output apb_resp_t apb_resp_o,
   output iob_req_t  iob_req_o,
   input  iob_resp_t iob_resp_i
);

   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_ACCESS = 2'd1,
      ST_DONE   = 2'd2
   } state_t;

   state_t state_q;
   state_t state_d;
   logic   ready_q;
   logic   ready_d;
   logic   answer;

   // Writes complete on ready_nxt, reads on rvalid_nxt
   assign answer = apb_req_i.write ? iob_resp_i.ready_nxt : iob_resp_i.rvalid_nxt;

   always_comb begin
      state_d = state_q;
      ready_d = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (apb_req_i.sel) begin  // Setup cycle seen
               state_d = ST_ACCESS;
            end
         end
         ST_ACCESS: begin
            if (answer) begin
               state_d = ST_DONE;
               ready_d = 1'b1;        // Shown next cycle with rdata
            end
         end
         ST_DONE: begin
            state_d = ST_IDLE;        // avalid low, request not repeated
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         ready_q <= 1'b0;
      end else begin
         state_q <= state_d;
         ready_q <= ready_d;
      end
   end

   always_comb begin
      iob_req_o.avalid = (state_q == ST_ACCESS);
      iob_req_o.addr   = apb_req_i.addr;
      iob_req_o.wdata  = apb_req_i.wdata;
      iob_req_o.wstrb  = apb_req_i.wstrb;
   end

   always_comb begin
      apb_resp_o.ready = ready_q;
      apb_resp_o.rdata = iob_resp_i.rdata;  // Held by the register bank
   end

endmodule

/* common/apb_iob_pkg.sv */
`include "apb_iob_macros.svh"

package apb_iob_pkg;

   // APB requester side
   typedef struct packed {
      logic                   sel;     // Peripheral select
      logic                   enable;  // Access phase
      logic                   write;
      logic [`APB_ADDR_W-1:0] addr;    // Byte address
      logic [`APB_DATA_W-1:0] wdata;
      logic [`APB_STRB_W-1:0] wstrb;   // Zero on reads
   } apb_req_t;

   typedef struct packed {
      logic                   ready;   // Ends the access phase
      logic [`APB_DATA_W-1:0] rdata;   // Valid with ready
   } apb_resp_t;

   // IOb manager side
   typedef struct packed {
      logic                   avalid;  // Request valid
      logic [`APB_ADDR_W-1:0] addr;
      logic [`APB_DATA_W-1:0] wdata;
      logic [`APB_STRB_W-1:0] wstrb;   // Nonzero marks a write
   } iob_req_t;

   typedef struct packed {
      logic                   rvalid_nxt;  // Read answered this cycle
      logic                   ready_nxt;   // Request accepted this cycle
      logic [`APB_DATA_W-1:0] rdata;       // Registered read data
   } iob_resp_t;

   // Register bank to timer
   typedef struct packed {
      logic                    en;
      logic                    reload;    // Wrap to 0 after compare
      logic [`TMR_PRESC_W-1:0] presc;
      logic [`TMR_COUNT_W-1:0] cmp;
      logic                    load;      // One-cycle COUNT load
      logic [`TMR_COUNT_W-1:0] load_val;
   } timer_cfg_t;

   // Timer to register bank
   typedef struct packed {
      logic [`TMR_COUNT_W-1:0] count;
      logic                    match;     // One-cycle pulse
   } timer_stat_t;

endpackage

/* common/apb_iob_macros.svh */
`ifndef APB_IOB_MACROS_SVH
`define APB_IOB_MACROS_SVH

// Bus widths
`define APB_ADDR_W 8
`define APB_DATA_W 32
`define APB_STRB_W (`APB_DATA_W / 8)

// Timer widths
`define TMR_PRESC_W 16
`define TMR_COUNT_W `APB_DATA_W

// Register map, byte offsets
`define REG_CTRL    8'h00
`define REG_PRESC   8'h04
`define REG_CMP     8'h08
`define REG_COUNT   8'h0C
`define REG_STATUS  8'h10
`define REG_SCRATCH 8'h14

// CTRL fields
`define CTRL_EN_BIT     0
`define CTRL_RELOAD_BIT 1
`define CTRL_IRQEN_BIT  2
`define CTRL_W          3

// STATUS fields
`define STATUS_MATCH_BIT 0

// Reset values
`define CTRL_RST    3'b000
`define PRESC_RST   16'h0000
`define CMP_RST     32'h0000_0000
`define SCRATCH_RST 32'h0000_0000
`define STATUS_RST  1'b0

`endif
